// ==== logic/dma_rsp_pkg.sv ====
package dma_rsp_pkg;

    // **********************************************************************
    // widths
    // **********************************************************************
    localparam int dma_data_w = 256;             // stream beat
    localparam int dma_keep_w = 8;               // one bit per dword, also dwords per beat
    localparam int dw_len_w   = 11;
    localparam int tag_w      = 8;
    localparam int addr_w     = 64;
    localparam int rsp_user_w = 128;
    localparam int hdr_dw     = 3;               // descriptor dwords in the first beat
    localparam int hdr_w      = hdr_dw * 32;
    localparam int hold_w     = dma_data_w - hdr_w;  // upper part kept between beats

    // converter states, one-hot
    localparam logic [2:0] st_idle = 3'b001;     // take descriptor beat, no output
    localparam logic [2:0] st_rsp  = 3'b010;     // merged beats
    localparam logic [2:0] st_last = 3'b100;     // final merged or hold-only beat

    // **********************************************************************
    // completion descriptor, msb first so bit positions match the wire
    // **********************************************************************
    typedef struct packed {
        logic              rsvd_95;
        logic [2:0]        attr;
        logic [2:0]        tc;
        logic              rsvd_88;
        logic [15:0]       completer_id;
        logic [tag_w-1:0]  tag;                  // 71:64
        logic [15:0]       requester_id;
        logic              rsvd_47;
        logic              poisoned;
        logic [2:0]        cpl_status;
        logic [10:0]       dw_count;             // 42:32
        logic              rsvd_31;
        logic              req_cpl;              // 30, request completed
        logic              locked;
        logic [12:0]       byte_count;           // 28:16
        logic [3:0]        error_code;
        logic [11:0]       lower_addr;           // 11:0
    } rc_desc_t;

    // first beat, read as descriptor + payload or as plain dwords
    typedef union packed {
        struct packed {
            logic [hold_w-1:0] payload;
            rc_desc_t          desc;
        } hdr;
        logic [dma_keep_w-1:0][31:0] dw;
    } rc_first_beat_u;

    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [dma_data_w-1:0] data;
        logic [dma_keep_w-1:0] keep;
    } rc_beat_t;

    // per-packet sideband, rsp_user_w bits
    typedef struct packed {
        logic [22:0]         rsvd_hi;
        logic                req_cpl;
        logic [tag_w-1:0]    tag;                // bit 7 picks the channel
        logic [addr_w-1:0]   addr;
        logic [12:0]         rsvd_lo;
        logic [dw_len_w-1:0] dw_len;
        logic [3:0]          first_be;
        logic [3:0]          last_be;
    } rsp_user_t;

    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [dma_data_w-1:0] data;
        rsp_user_t             user;
        logic [dma_keep_w-1:0] keep;
    } rsp_beat_t;

endpackage

// ==== logic/rc_desc_decode.sv ====
`timescale 1ns/1ps

module rc_desc_decode import dma_rsp_pkg::*; (
    input  rc_first_beat_u      beat,
    output rsp_user_t           user,
    output logic [dw_len_w-1:0] dw_len,
    output logic                tail_in_hold
);

    rc_desc_t   desc;
    logic [1:0] end_off;   // byte offset just past the last payload byte
    logic [3:0] first_be;
    logic [3:0] last_be;

    assign desc    = beat.hdr.desc;
    assign dw_len  = desc.dw_count;
    assign end_off = desc.lower_addr[1:0] + desc.byte_count[1:0];  // wraps mod 4

    // byte enables of the first and last dword
    always_comb begin
        first_be = 4'b1111 << desc.lower_addr[1:0];
        if (!desc.req_cpl) begin
            last_be = 4'b1111;               // more completions follow, full dword
        end else begin
            case (end_off)
                2'd1:    last_be = 4'b0001;
                2'd2:    last_be = 4'b0011;
                2'd3:    last_be = 4'b0111;
                default: last_be = 4'b1111;
            endcase
        end
    end

    always_comb begin
        user          = '0;
        user.req_cpl  = desc.req_cpl;
        user.tag      = desc.tag;
        user.addr     = {{(addr_w - 12){1'b0}}, desc.lower_addr[11:2], 2'b00};
        user.dw_len   = desc.dw_count;
        if (desc.dw_count == dw_len_w'(1)) begin
            // single dword, both enables land on it
            user.first_be = first_be & last_be;
            user.last_be  = 4'b0000;
        end else begin
            user.first_be = first_be;
            user.last_be  = last_be;
        end
    end

    // 1..5 dwords left over sit fully inside the held 160 bits
    assign tail_in_hold = (dw_len[2:0] != 3'd0) && (dw_len[2:0] <= 3'd5);

endmodule

// ==== logic/rsp_converter.sv ====
`timescale 1ns/1ps

module rsp_converter import dma_rsp_pkg::*; (
    input  logic      dma_clk,
    input  logic      rst_n,
    input  rc_beat_t  rc_in,
    output logic      rc_ready,
    output rsp_beat_t cnv_out,
    input  logic      cnv_ready
);

    // **********************************************************************
    // declarations
    // **********************************************************************
    rc_first_beat_u        in_beat;     // current input word, two views
    rsp_user_t             dec_user;    // sideband decoded from a first beat
    logic [dw_len_w-1:0]   dec_dw_len;
    logic                  dec_tail;

    logic [2:0]            state_q;
    logic [2:0]            state_d;
    logic                  is_idle;
    logic                  is_rsp;
    logic                  is_last;

    rsp_user_t             user_q;      // sideband of the packet in flight
    logic [dw_len_w-1:0]   dw_left_q;   // dwords not yet sent
    logic                  tail_q;      // packet ends in a hold-only beat
    logic [hold_w-1:0]     hold_q;      // upper 160 bits of the last accepted beat

    logic                  rc_fire;
    logic                  cnv_fire;
    logic                  out_valid;
    logic                  hold_only;
    logic [dma_data_w-1:0] out_data;
    logic [dma_keep_w-1:0] out_keep;

    assign in_beat = rc_in.data;

    rc_desc_decode desc_dec_i (
        .beat         (in_beat),
        .user         (dec_user),
        .dw_len       (dec_dw_len),
        .tail_in_hold (dec_tail)
    );

    assign is_idle = (state_q == st_idle);
    assign is_rsp  = (state_q == st_rsp);
    assign is_last = (state_q == st_last);

    assign hold_only = is_last & tail_q;   // extra beat from hold_q alone

    // **********************************************************************
    // handshake
    // **********************************************************************
    // idle always takes the descriptor beat, hold-only beat takes nothing
    assign rc_ready  = is_idle | ((is_rsp | (is_last & ~tail_q)) & cnv_ready);
    assign out_valid = (is_rsp & rc_in.valid) | (is_last & (tail_q | rc_in.valid));
    assign rc_fire   = rc_in.valid & rc_ready;
    assign cnv_fire  = out_valid & cnv_ready;

    // **********************************************************************
    // fsm
    // **********************************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (rc_fire) begin
                    // one output beat in total -> straight to last
                    if (dec_dw_len <= dw_len_w'(dma_keep_w)) begin
                        state_d = st_last;
                    end else begin
                        state_d = st_rsp;
                    end
                end
            end
            st_rsp: begin
                // after this beat at most one beat is left
                if (cnv_fire && (dw_left_q <= dw_len_w'(2 * dma_keep_w))) begin
                    state_d = st_last;
                end
            end
            st_last: begin
                if (cnv_fire) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;   // illegal one-hot code
        endcase
    end

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // **********************************************************************
    // per-packet state
    // **********************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            user_q    <= '0;
            dw_left_q <= '0;
            tail_q    <= 1'b0;
        end else if (is_idle && rc_fire) begin
            user_q    <= dec_user;            // descriptor beat
            dw_left_q <= dec_dw_len;
            tail_q    <= dec_tail;
        end else if (cnv_fire) begin
            dw_left_q <= dw_left_q - dw_len_w'(dma_keep_w);  // eight dwords out
        end
    end

    // payload carried over to the next output beat
    always_ff @(posedge dma_clk) begin
        if (rc_fire) begin
            hold_q <= in_beat.dw[dma_keep_w-1:hdr_dw];
        end
    end

    // **********************************************************************
    // output beat
    // **********************************************************************
    always_comb begin
        if (hold_only) begin
            out_data = {{hdr_w{1'b0}}, hold_q};
        end else begin
            out_data = {in_beat.dw[hdr_dw-1:0], hold_q};   // low 3 dwords go on top
        end
    end

    // low min(8, dw_left) lanes
    always_comb begin
        for (int i = 0; i < dma_keep_w; i++) begin
            out_keep[i] = (dw_left_q > dw_len_w'(i));
        end
    end

    always_comb begin
        cnv_out.valid = out_valid;
        cnv_out.last  = out_valid & is_last;
        cnv_out.data  = out_data;
        cnv_out.user  = out_valid ? user_q : rsp_user_t'({rsp_user_w{1'b0}});
        cnv_out.keep  = out_keep;
    end

endmodule

// ==== logic/rsp_distributor.sv ====
`timescale 1ns/1ps

module rsp_distributor import dma_rsp_pkg::*; (
    input  logic      dma_clk,
    input  logic      rst_n,
    input  rsp_beat_t cnv_out,
    output logic      cnv_ready,
    output rsp_beat_t ch0_out,
    input  logic      ch0_ready,
    output rsp_beat_t ch1_out,
    input  logic      ch1_ready
);

    // **********************************************************************
    // route selection
    // **********************************************************************
    logic busy_q;     // inside a packet
    logic route_q;    // channel latched at the first beat
    logic tag_ch;     // channel named by the current beat
    logic sel;        // 0 -> ch0, 1 -> ch1
    logic cnv_fire;

    assign tag_ch = cnv_out.user.tag[tag_w-1];
    assign sel    = busy_q ? route_q : tag_ch;   // first beat routes directly

    // ready comes from the selected consumer only
    assign cnv_ready = sel ? ch1_ready : ch0_ready;
    assign cnv_fire  = cnv_out.valid & cnv_ready;

    // held until the last beat goes through
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            route_q <= 1'b0;
        end else if (cnv_fire) begin
            if (cnv_out.last) begin
                busy_q  <= 1'b0;            // packet done
            end else if (!busy_q) begin
                busy_q  <= 1'b1;            // first beat of a multi-beat packet
                route_q <= tag_ch;
            end
        end
    end

    // **********************************************************************
    // channel outputs
    // **********************************************************************
    always_comb begin
        ch0_out = '0;   // unselected side stays all zero
        ch1_out = '0;
        if (sel) begin
            ch1_out = cnv_out;
        end else begin
            ch0_out = cnv_out;
        end
    end

endmodule

// ==== logic/dma_rsp_top.sv ====
`timescale 1ns/1ps

module dma_rsp_top import dma_rsp_pkg::*; (
    input  logic      dma_clk,
    input  logic      rst_n,

    // completions from the pcie core
    input  rc_beat_t  rc_in,
    output logic      rc_ready,

    // read channel 0, tag bit 7 clear
    output rsp_beat_t ch0_out,
    input  logic      ch0_ready,

    // read channel 1, tag bit 7 set
    output rsp_beat_t ch1_out,
    input  logic      ch1_ready
);

    rsp_beat_t cnv_out;     // aligned packets
    logic      cnv_ready;

    // strip descriptor, realign payload
    rsp_converter converter_i (
        .dma_clk   (dma_clk),
        .rst_n     (rst_n),
        .rc_in     (rc_in),
        .rc_ready  (rc_ready),
        .cnv_out   (cnv_out),
        .cnv_ready (cnv_ready)
    );

    // split by tag
    rsp_distributor distributor_i (
        .dma_clk   (dma_clk),
        .rst_n     (rst_n),
        .cnv_out   (cnv_out),
        .cnv_ready (cnv_ready),
        .ch0_out   (ch0_out),
        .ch0_ready (ch0_ready),
        .ch1_out   (ch1_out),
        .ch1_ready (ch1_ready)
    );

endmodule

// ==== verification/dma_rsp_assert.sv ====
`timescale 1ns/1ps

module dma_rsp_assert import dma_rsp_pkg::*; (
    input logic      dma_clk,
    input logic      rst_n,
    input rc_beat_t  rc_in,
    input logic      rc_ready,
    input rsp_beat_t cnv_out,
    input logic      cnv_ready,
    input rsp_beat_t ch0_out,
    input logic      ch0_ready,
    input rsp_beat_t ch1_out,
    input logic      ch1_ready
);

    // **********************************************************************
    // stalled beats keep valid and contents
    // **********************************************************************
    rc_hold_a: assert property (@(posedge dma_clk) disable iff (!rst_n)
        rc_in.valid && !rc_ready |=> rc_in.valid && $stable(rc_in))
        else $error("rc_in changed while stalled");

    cnv_hold_a: assert property (@(posedge dma_clk) disable iff (!rst_n)
        cnv_out.valid && !cnv_ready |=> cnv_out.valid && $stable(cnv_out))
        else $error("cnv_out changed while stalled");

    ch0_hold_a: assert property (@(posedge dma_clk) disable iff (!rst_n)
        ch0_out.valid && !ch0_ready |=> ch0_out.valid && $stable(ch0_out))
        else $error("ch0_out changed while stalled");

    ch1_hold_a: assert property (@(posedge dma_clk) disable iff (!rst_n)
        ch1_out.valid && !ch1_ready |=> ch1_out.valid && $stable(ch1_out))
        else $error("ch1_out changed while stalled");

    // valids known once out of reset
    valid_known_a: assert property (@(posedge dma_clk) disable iff (!rst_n)
        !$isunknown({rc_in.valid, cnv_out.valid, ch0_out.valid, ch1_out.valid}))
        else $error("unknown value on a valid");

    one_channel_a: assert property (@(posedge dma_clk) disable iff (!rst_n)
        !(ch0_out.valid && ch1_out.valid))
        else $error("both channels valid at once");

    user_idle_a: assert property (@(posedge dma_clk) disable iff (!rst_n)
        !cnv_out.valid |-> (cnv_out.user == '0))
        else $error("cnv_out user not zero while idle");

endmodule

bind dma_rsp_top dma_rsp_assert assert_i (.*);

// ==== verification/dma_rsp_tb.sv ====
`timescale 1ns/1ps

module dma_rsp_tb import dma_rsp_pkg::*; ();

    localparam int          clk_half     = 20;      // 40 ns period
    localparam int          rst_cycles   = 16;
    localparam int          stall_margin = 8;       // cycles allowed per beat
    localparam int          n_rounds     = 2;       // round 0 with input gaps, round 1 without
    localparam logic [31:0] rng_seed     = 32'h48dd_3da8;

    // one completion, expected byte enables worked out by hand
    typedef struct packed {
        logic [7:0]  tag;
        int          len;
        logic [11:0] la;
        logic [12:0] bc;
        logic        rc;
        logic [3:0]  fbe;
        logic [3:0]  lbe;
    } cpl_row_t;

    logic        dma_clk;
    logic        rst_n;
    rc_beat_t    rc_in;
    logic        rc_ready;
    rsp_beat_t   ch0_out;
    rsp_beat_t   ch1_out;
    logic        ch0_ready;
    logic        ch1_ready;

    cpl_row_t    cpl_tab[$];
    rsp_beat_t   exp_q0[$];     // per channel, in packet order
    rsp_beat_t   exp_q1[$];
    int          exp_total;
    int          seen;
    int          wd_cycles;

    dma_rsp_top dut_i (.*);

    initial begin
        dma_clk = 1'b0;
        forever #clk_half dma_clk = ~dma_clk;
    end

    // **********************************************************************
    // completion table
    // **********************************************************************
    task automatic add_row(input logic [7:0] tag, input int len, input logic [11:0] la,
                           input logic [12:0] bc, input logic rc,
                           input logic [3:0] fbe, input logic [3:0] lbe);
        cpl_tab.push_back('{tag, len, la, bc, rc, fbe, lbe});
    endtask

    task automatic load_table();
        //      tag    len  lower addr byte cnt  rc    fbe   lbe
        add_row(8'h01,  1, 12'h104, 13'd4,    1'b1, 4'hf, 4'h0);  // merged enables
        add_row(8'h82,  1, 12'h00a, 13'd1,    1'b1, 4'h4, 4'h0);
        add_row(8'h03,  2, 12'h3f1, 13'd7,    1'b1, 4'he, 4'hf);
        add_row(8'h84,  3, 12'h012, 13'd10,   1'b1, 4'hc, 4'hf);
        add_row(8'h05,  4, 12'h020, 13'd15,   1'b1, 4'hf, 4'h7);
        add_row(8'h86,  5, 12'h7ff, 13'd17,   1'b1, 4'h8, 4'hf);
        add_row(8'h87,  6, 12'h040, 13'd22,   1'b1, 4'hf, 4'h3);
        add_row(8'h08,  7, 12'h101, 13'd200,  1'b0, 4'he, 4'hf);  // more completions follow
        add_row(8'h09,  8, 12'h000, 13'd32,   1'b1, 4'hf, 4'hf);
        add_row(8'h8a,  9, 12'h203, 13'd34,   1'b1, 4'h8, 4'h1);
        add_row(8'h0b, 10, 12'h00e, 13'd512,  1'b0, 4'hc, 4'hf);
        add_row(8'h8c, 11, 12'h080, 13'd41,   1'b1, 4'hf, 4'h1);
        add_row(8'h8d, 12, 12'h0c1, 13'd46,   1'b1, 4'he, 4'h7);
        add_row(8'h0e, 13, 12'h0c2, 13'd50,   1'b1, 4'hc, 4'hf);
        add_row(8'h0f, 14, 12'h0c3, 13'd53,   1'b1, 4'h8, 4'hf);
        add_row(8'h90, 15, 12'h100, 13'd58,   1'b1, 4'hf, 4'h3);
        add_row(8'h11, 16, 12'h200, 13'd64,   1'b1, 4'hf, 4'hf);
        add_row(8'h92, 17, 12'h301, 13'd66,   1'b1, 4'he, 4'h7);
        add_row(8'h93, 18, 12'h402, 13'd69,   1'b1, 4'hc, 4'h7);
        add_row(8'h14, 19, 12'h503, 13'd1000, 1'b0, 4'h8, 4'hf);
        add_row(8'h95, 20, 12'h604, 13'd79,   1'b1, 4'hf, 4'h7);
        add_row(8'h16, 21, 12'h705, 13'd82,   1'b1, 4'he, 4'h7);
        add_row(8'h97, 22, 12'h806, 13'd85,   1'b1, 4'hc, 4'h7);
        add_row(8'h18, 23, 12'h907, 13'd90,   1'b1, 4'h8, 4'h1);
        add_row(8'h99, 24, 12'hffc, 13'd96,   1'b1, 4'hf, 4'hf);
        add_row(8'h1a,  1, 12'h0f3, 13'd1,    1'b0, 4'h8, 4'h0);  // merge with rc clear
    endtask

    function automatic int total_beats();
        int n;
        n = 0;
        foreach (cpl_tab[i]) begin
            n += (hdr_dw + cpl_tab[i].len + 7) / 8;   // input beats
            n += (cpl_tab[i].len + 7) / 8;            // output beats
        end
        return n * n_rounds;
    endfunction

    function automatic logic [31:0] payload_dw(input logic [7:0] tag, input int i);
        return {tag, 24'd0} + 32'(i);
    endfunction

    // dword idx of the whole completion, descriptor first
    function automatic logic [31:0] stream_dw(input cpl_row_t r, input rc_desc_t d,
                                              input int idx);
        logic [31:0] v;
        if (idx < hdr_dw) begin
            v = d[idx*32 +: 32];
        end else if (idx < hdr_dw + r.len) begin
            v = payload_dw(r.tag, idx - hdr_dw);
        end else begin
            v = 32'hffff_ffff;                 // past the payload
        end
        return v;
    endfunction

    // **********************************************************************
    // reporting
    // **********************************************************************
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    // **********************************************************************
    // driver
    // **********************************************************************
    task automatic draw_ready();
        ch0_ready = ($urandom_range(3, 0) != 0);   // ready about 3 cycles in 4
        ch1_ready = ($urandom_range(3, 0) != 0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge dma_clk);
            draw_ready();
            rc_in = '0;
        end
    endtask

    task automatic queue_expected(input cpl_row_t r);
        rsp_beat_t e;
        int        n_out;
        int        left;
        n_out = (r.len + 7) / 8;
        for (int b = 0; b < n_out; b++) begin
            left            = r.len - 8 * b;
            e               = '0;
            e.valid         = 1'b1;
            e.last          = (b == n_out - 1);
            e.user.req_cpl  = r.rc;
            e.user.tag      = r.tag;
            e.user.addr     = 64'(r.la & 12'hffc);   // dword aligned
            e.user.dw_len   = 11'(r.len);
            e.user.first_be = r.fbe;
            e.user.last_be  = r.lbe;
            for (int l = 0; l < dma_keep_w; l++) begin
                if (l < left) begin
                    e.keep[l]          = 1'b1;
                    e.data[l*32 +: 32] = payload_dw(r.tag, 8 * b + l);
                end
            end
            if (r.tag[7]) begin
                exp_q1.push_back(e);
            end else begin
                exp_q0.push_back(e);
            end
        end
    endtask

    task automatic send_cpl(input cpl_row_t r, input bit gaps);
        rc_desc_t d;
        rc_beat_t beat;
        int       n_in;
        int       idx;
        d              = '0;
        d.lower_addr   = r.la;
        d.byte_count   = r.bc;
        d.req_cpl      = r.rc;
        d.dw_count     = 11'(r.len);
        d.tag          = r.tag;
        d.requester_id = 16'h00a5;    // not carried to the output
        d.completer_id = 16'h5a00;
        n_in           = (hdr_dw + r.len + 7) / 8;
        for (int j = 0; j < n_in; j++) begin
            beat       = '0;
            beat.valid = 1'b1;
            beat.last  = (j == n_in - 1);
            for (int l = 0; l < dma_keep_w; l++) begin
                idx                   = 8 * j + l;
                beat.data[l*32 +: 32] = stream_dw(r, d, idx);
                beat.keep[l]          = (idx < hdr_dw + r.len);
            end
            if (gaps) begin
                idle_cycles($urandom_range(2, 0));
            end
            @(negedge dma_clk);
            draw_ready();
            rc_in = beat;
            @(posedge dma_clk);
            while (!rc_ready) begin                    // hold until taken
                @(negedge dma_clk);
                draw_ready();
                @(posedge dma_clk);
            end
        end
    endtask

    // **********************************************************************
    // monitors and scoreboard
    // **********************************************************************
    task automatic check_beat(input int ch, input rsp_beat_t got);
        rsp_beat_t             e;
        logic [dma_data_w-1:0] mask;
        assert ((ch == 0 && exp_q0.size() > 0) || (ch == 1 && exp_q1.size() > 0))
            else begin
                $display("channel %0d delivered a beat while no packet was pending for it", ch);
                abort_run();
            end
        if (ch == 0) begin
            e = exp_q0.pop_front();
        end else begin
            e = exp_q1.pop_front();
        end
        for (int l = 0; l < dma_keep_w; l++) begin
            mask[l*32 +: 32] = {32{e.keep[l]}};   // only kept lanes carry payload
        end
        assert (got.keep == e.keep)
            else value_error($sformatf("ch%0d tag %h keep %b, expected %b",
                                       ch, e.user.tag, got.keep, e.keep));
        assert (got.last == e.last)
            else value_error($sformatf("ch%0d tag %h last %b, expected %b",
                                       ch, e.user.tag, got.last, e.last));
        assert (got.user == e.user)
            else value_error($sformatf("ch%0d tag %h user %h, expected %h",
                                       ch, e.user.tag, got.user, e.user));
        assert ((got.data & mask) == e.data)
            else value_error($sformatf("ch%0d tag %h data %h, expected %h",
                                       ch, e.user.tag, got.data & mask, e.data));
        seen++;
    endtask

    always @(posedge dma_clk) begin
        if (rst_n) begin
            if (ch0_out.valid && ch0_ready) begin
                check_beat(0, ch0_out);
            end
            if (ch1_out.valid && ch1_ready) begin
                check_beat(1, ch1_out);
            end
        end
    end

    initial begin : watchdog
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge dma_clk);
        $display("timeout after %0d cycles, only %0d of %0d expected beats arrived",
                 wd_cycles, seen, exp_total);
        abort_run();
    end

    // **********************************************************************
    // main sequence
    // **********************************************************************
    initial begin : main
        void'($urandom(rng_seed));
        rst_n     = 1'b0;
        rc_in     = '0;
        ch0_ready = 1'b0;
        ch1_ready = 1'b0;
        seen      = 0;
        exp_total = 0;
        load_table();
        foreach (cpl_tab[i]) begin
            exp_total += n_rounds * ((cpl_tab[i].len + 7) / 8);
        end
        wd_cycles = rst_cycles + stall_margin * total_beats();
        repeat (rst_cycles) @(negedge dma_clk);
        // idle converter takes a beat, both channels quiet
        assert (rc_ready === 1'b1 && ch0_out.valid === 1'b0 && ch1_out.valid === 1'b0)
            else value_error($sformatf("reset: rc_ready %b ch0 valid %b ch1 valid %b, %s",
                                       rc_ready, ch0_out.valid, ch1_out.valid,
                                       "expected 1 0 0"));
        rst_n = 1'b1;
        for (int rnd = 0; rnd < n_rounds; rnd++) begin
            foreach (cpl_tab[i]) begin
                queue_expected(cpl_tab[i]);
                send_cpl(cpl_tab[i], rnd == 0);
            end
        end
        @(negedge dma_clk);
        rc_in = '0;
        while (seen < exp_total) begin       // drain under random ready
            draw_ready();
            @(negedge dma_clk);
        end
        ch0_ready = 1'b1;                    // a stray extra beat would show now
        ch1_ready = 1'b1;
        repeat (4) @(negedge dma_clk);
        if (rc_ready && !ch0_out.valid && !ch1_out.valid) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("streams did not return to idle after the last packet");
            abort_run();
        end
    end

endmodule

// ==== sim.f ====
logic/dma_rsp_pkg.sv
logic/rc_desc_decode.sv
logic/rsp_converter.sv
logic/rsp_distributor.sv
logic/dma_rsp_top.sv
verification/dma_rsp_assert.sv
verification/dma_rsp_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := dma_rsp_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
